// File: logic/core_pkg.sv
// core widths and counts shared by every block; pc is byte addressed with fixed 4-byte steps
`default_nettype none

package core_pkg;

  ////////////////////////////////////////////////////////////
  // datapath sizes
  ////////////////////////////////////////////////////////////

  // data word and program counter share one width
  localparam int xlen = 32;

  // register bank depths, the top passes these down as parameters
  localparam int num_gpr = 32;
  localparam int num_spr = 8;

  ////////////////////////////////////////////////////////////
  // program counter
  ////////////////////////////////////////////////////////////

  // increment per instruction
  localparam logic [xlen-1:0] pc_step = 4;
  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0080;

  // shared register port address
  typedef logic [11:0] reg_addr_t;

endpackage

`default_nettype wire

// File: logic/dbg_pkg.sv
// host address map and debug state encodings; only the low 11 address bits decode in the region
`default_nettype none

package dbg_pkg;

  ////////////////////////////////////////////////////////////
  // host address map
  ////////////////////////////////////////////////////////////

  typedef logic [15:0] dbg_addr_t;

  // addr[15:11] selects the debug registers
  localparam logic [4:0] dbg_region = 5'b00110;
  // addr[15:10] selects the general registers
  localparam logic [5:0] gpr_prefix = 6'b000001;

  // offsets inside the debug region
  localparam logic [10:0] dbg_npc_off  = 11'd0;
  localparam logic [10:0] dbg_ppc_off  = 11'd1;
  localparam logic [10:0] dbg_dmr1_off = 11'd16;
  localparam logic [10:0] dbg_dsr_off  = 11'd20;

  // dmr1 keeps single step and branch trace
  localparam int dmr1_st_bit = 22;
  localparam int dmr1_w      = 2;
  // dsr keeps iie and inte
  localparam int dsr_lo_bit  = 6;
  localparam int dsr_w       = 2;

  // breakpoint fsm
  typedef enum logic [1:0] {idle, debug_stall, stall_core} bp_state_t;
  // which stages hold the ppc/npc pair
  typedef enum logic [1:0] {ifid, ifex, idex} pc_track_t;

endpackage

`default_nettype wire

// File: logic/reg_port_if.sv
// shared register port with no handshake; rdata follows addr in the same cycle
`timescale 1ns/1ps
`default_nettype none

interface reg_port_if;

  import core_pkg::*;

  // access strobe, held for the cycle of the access
  logic            req;
  // write enable, the write lands at the next rising edge
  logic            we;
  reg_addr_t       addr;
  logic [xlen-1:0] wdata;
  // combinational read data from the addressed entry
  logic [xlen-1:0] rdata;

  // side that issues the access
  modport initiator (
    output req, we, addr, wdata,
    input  rdata
  );

  // side that holds the storage
  modport target (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: logic/dbg_ctrl.sv
// register access is forwarded only while halted; a strobe without ack changes nothing
`timescale 1ns/1ps
`default_nettype none

module dbg_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  // host side
  input  logic                     dbg_stall_i,
  input  logic                     dbg_strobe_i,
  input  logic                     dbg_we_i,
  input  dbg_pkg::dbg_addr_t       dbg_addr_i,
  input  logic [core_pkg::xlen-1:0] dbg_wdata_i,
  output logic                     dbg_ack_o,
  output logic                     dbg_bp_o,
  output logic [core_pkg::xlen-1:0] dbg_rdata_o,
  // core side
  input  logic                     trap_i,
  input  logic                     branch_in_ex_i,
  input  logic                     branch_taken_i,
  input  logic [core_pkg::xlen-1:0] pc_if_i,
  input  logic [core_pkg::xlen-1:0] pc_id_i,
  input  logic [core_pkg::xlen-1:0] branch_pc_i,
  output logic                     stall_core_o,
  output logic                     stop_req_o,
  output logic                     step_en_o,
  output logic                     set_npc_o,
  output logic [1:0]               dsr_o,
  output logic [core_pkg::xlen-1:0] npc_o,
  // register port
  output logic                     sel_spr_o,
  reg_port_if.initiator            reg_port
);

  import core_pkg::*;
  import dbg_pkg::*;

  bp_state_t          bp_q, bp_d;
  pc_track_t          trk_q, trk_d;
  logic [dmr1_w-1:0]  dmr1_q, dmr1_d;
  logic [dsr_w-1:0]   dsr_q, dsr_d;
  logic [xlen-1:0]    ppc_cur;
  logic [xlen-1:0]    npc_cur;
  logic               in_region;
  logic               gpr_sel;
  logic               halted;
  logic               port_hit;

  // first decode stage
  assign in_region = (dbg_addr_i[15:11] == dbg_region);
  assign gpr_sel   = (dbg_addr_i[15:10] == gpr_prefix);
  assign halted    = (bp_q == stall_core);
  assign dbg_ack_o = dbg_strobe_i && (in_region || halted);

  assign step_en_o = dmr1_q[0];
  assign dsr_o     = dsr_q;
  // npc is loaded straight from host write data
  assign npc_o     = dbg_wdata_i;

  ////////////////////////////////////////////////////////////
  // breakpoint fsm
  ////////////////////////////////////////////////////////////

  always_comb begin
    bp_d         = bp_q;
    stall_core_o = 1'b0;
    stop_req_o   = 1'b0;
    dbg_bp_o     = 1'b0;
    case (bp_q)
      idle: begin
        // a core trap wins over a host stall
        if (trap_i) begin
          dbg_bp_o     = 1'b1;
          stall_core_o = 1'b1;
          bp_d         = stall_core;
        end else if (dbg_stall_i) begin
          stop_req_o = 1'b1;
          bp_d       = debug_stall;
        end
      end
      debug_stall: begin
        // hold the pipeline until the drain trap arrives
        stop_req_o = 1'b1;
        if (trap_i) begin
          stall_core_o = 1'b1;
          bp_d         = stall_core;
        end
      end
      stall_core: begin
        stall_core_o = 1'b1;
        if (!dbg_stall_i) begin
          bp_d = idle;
        end
      end
      default: bp_d = idle;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // register port and second decode stage
  ////////////////////////////////////////////////////////////

  assign port_hit      = dbg_strobe_i && !in_region && halted;
  assign reg_port.req  = port_hit;
  assign reg_port.we   = port_hit && dbg_we_i;
  assign reg_port.addr = gpr_sel ? reg_addr_t'(dbg_addr_i[4:0]) : dbg_addr_i[11:0];
  assign reg_port.wdata = dbg_wdata_i;
  // anything outside the gpr prefix goes to the special bank
  assign sel_spr_o     = port_hit && !gpr_sel;

  always_comb begin
    dmr1_d      = dmr1_q;
    dsr_d       = dsr_q;
    set_npc_o   = 1'b0;
    dbg_rdata_o = '0;
    if (dbg_strobe_i && in_region) begin
      case (dbg_addr_i[10:0])
        dbg_npc_off: begin
          set_npc_o   = dbg_we_i;
          dbg_rdata_o = npc_cur;
        end
        dbg_ppc_off: dbg_rdata_o = ppc_cur;
        dbg_dmr1_off: begin
          if (dbg_we_i) begin
            dmr1_d = dbg_wdata_i[dmr1_st_bit +: dmr1_w];
          end else begin
            dbg_rdata_o[dmr1_st_bit +: dmr1_w] = dmr1_q;
          end
        end
        dbg_dsr_off: begin
          if (dbg_we_i) begin
            dsr_d = dbg_wdata_i[dsr_lo_bit +: dsr_w];
          end else begin
            dbg_rdata_o[dsr_lo_bit +: dsr_w] = dsr_q;
          end
        end
        // unmapped offsets read zero
        default: ;
      endcase
    end else if (port_hit && !dbg_we_i) begin
      dbg_rdata_o = reg_port.rdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // ppc/npc tracking
  ////////////////////////////////////////////////////////////

  always_comb begin
    trk_d   = trk_q;
    ppc_cur = pc_id_i;
    npc_cur = pc_if_i;
    case (trk_q)
      ifid: ;
      ifex: ppc_cur = branch_pc_i;
      idex: begin
        ppc_cur = branch_pc_i;
        npc_cur = pc_id_i;
        // a new npc replaces the fall-through in id
        if (set_npc_o) begin
          trk_d = ifex;
        end
      end
      default: trk_d = ifid;
    endcase
    // capture on the cycle the core gets stalled
    if (stall_core_o && !halted) begin
      if (!branch_in_ex_i) begin
        trk_d = ifid;
      end else if (branch_taken_i) begin
        trk_d = ifex;
      end else begin
        trk_d = idex;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bp_q   <= idle;
      trk_q  <= ifid;
      dmr1_q <= '0;
      dsr_q  <= '0;
    end else begin
      bp_q   <= bp_d;
      trk_q  <= trk_d;
      dmr1_q <= dmr1_d;
      dsr_q  <= dsr_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/pc_stepper.sv
// stands in for the core front end; no fetch or decode, branches come straight from the ports
`timescale 1ns/1ps
`default_nettype none

module pc_stepper (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     stall_i,
  input  logic                     stop_req_i,
  input  logic                     step_en_i,
  input  logic                     set_npc_i,
  input  logic [core_pkg::xlen-1:0] npc_i,
  input  logic                     ebreak_i,
  input  logic                     branch_ex_i,
  input  logic                     branch_taken_i,
  input  logic [core_pkg::xlen-1:0] branch_target_i,
  output logic                     trap_o,
  output logic                     branch_in_ex_o,
  output logic                     branch_taken_o,
  output logic [core_pkg::xlen-1:0] pc_if_o,
  output logic [core_pkg::xlen-1:0] pc_id_o,
  output logic [core_pkg::xlen-1:0] pc_ex_o
);

  import core_pkg::*;

  logic [xlen-1:0] pc_if_q, pc_id_q, pc_ex_q;
  logic            run;
  logic            take;
  // pulses one cycle after stop_req first shows up
  logic            drain_q;
  // set while halted with single step on
  logic            step_armed_q;
  // set for the cycle after the single advance
  logic            step_done_q;

  assign run  = !stall_i && !stop_req_i;
  assign take = branch_ex_i && branch_taken_i;

  // one trap source for the debug fsm
  assign trap_o         = ebreak_i || drain_q || step_done_q;
  assign branch_in_ex_o = branch_ex_i;
  assign branch_taken_o = take;

  assign pc_if_o = pc_if_q;
  assign pc_id_o = pc_id_q;
  assign pc_ex_o = pc_ex_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_if_q      <= reset_pc;
      pc_id_q      <= reset_pc;
      pc_ex_q      <= reset_pc;
      drain_q      <= 1'b0;
      step_armed_q <= 1'b0;
      step_done_q  <= 1'b0;
    end else begin
      // host npc load beats a normal advance
      if (set_npc_i) begin
        pc_if_q <= npc_i;
      end else if (run) begin
        pc_if_q <= take ? branch_target_i : pc_if_q + pc_step;
        pc_id_q <= pc_if_q;
        pc_ex_q <= pc_id_q;
      end
      drain_q <= stop_req_i && !drain_q;
      if (stall_i) begin
        step_armed_q <= step_en_i;
        step_done_q  <= 1'b0;
      end else if (run) begin
        step_done_q  <= step_armed_q;
        step_armed_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/reg_file_arb.sv
// core writeback reaches general registers only; out-of-range entries read zero and drop writes
`timescale 1ns/1ps
`default_nettype none

module reg_file_arb #(
  parameter int num_gpr = 32,
  parameter int num_spr = 8
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // core writeback
  input  logic                      core_we_i,
  input  core_pkg::reg_addr_t       core_waddr_i,
  input  logic [core_pkg::xlen-1:0] core_wdata_i,
  // debug side
  input  logic                      dbg_grant_i,
  input  logic                      sel_spr_i,
  reg_port_if.target                dbg_port
);

  import core_pkg::*;

  localparam int gpr_aw = (num_gpr > 1) ? $clog2(num_gpr) : 1;
  localparam int spr_aw = (num_spr > 1) ? $clog2(num_spr) : 1;

  logic [xlen-1:0] gpr_q [num_gpr];
  logic [xlen-1:0] spr_q [num_spr];
  logic [xlen-1:0] rd_data;
  logic            dbg_gpr_hit;
  logic            dbg_spr_hit;
  logic            core_hit;
  logic            dbg_wr;
  logic            core_wr;

  // range checks against the bank depth
  assign dbg_gpr_hit = (int'(dbg_port.addr) < num_gpr);
  assign dbg_spr_hit = (int'(dbg_port.addr) < num_spr);
  assign core_hit    = (int'(core_waddr_i) < num_gpr);

  // debug owns the banks while the core is halted
  assign dbg_wr  = dbg_grant_i && dbg_port.req && dbg_port.we;
  // core writes during a halt are lost
  assign core_wr = !dbg_grant_i && core_we_i && core_hit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_gpr; i++) begin
        gpr_q[i] <= '0;
      end
      for (int j = 0; j < num_spr; j++) begin
        spr_q[j] <= '0;
      end
    end else if (dbg_wr) begin
      if (sel_spr_i && dbg_spr_hit) begin
        spr_q[dbg_port.addr[spr_aw-1:0]] <= dbg_port.wdata;
      end else if (!sel_spr_i && dbg_gpr_hit) begin
        gpr_q[dbg_port.addr[gpr_aw-1:0]] <= dbg_port.wdata;
      end
    end else if (core_wr) begin
      gpr_q[core_waddr_i[gpr_aw-1:0]] <= core_wdata_i;
    end
  end

  // read mux for the debug port
  always_comb begin
    rd_data = '0;
    if (sel_spr_i) begin
      if (dbg_spr_hit) begin
        rd_data = spr_q[dbg_port.addr[spr_aw-1:0]];
      end
    end else if (dbg_gpr_hit) begin
      rd_data = gpr_q[dbg_port.addr[gpr_aw-1:0]];
    end
  end

  assign dbg_port.rdata = rd_data;

endmodule

`default_nettype wire

// File: logic/dbg_subsys_top.sv
// host holds dbg_stall_i until halted_o; branches and writebacks are driven from outside
`timescale 1ns/1ps
`default_nettype none

module dbg_subsys_top #(
  parameter int num_gpr = core_pkg::num_gpr,
  parameter int num_spr = core_pkg::num_spr
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // host port
  input  logic                      dbg_stall_i,
  input  logic                      dbg_strobe_i,
  input  logic                      dbg_we_i,
  input  dbg_pkg::dbg_addr_t        dbg_addr_i,
  input  logic [core_pkg::xlen-1:0] dbg_wdata_i,
  output logic                      dbg_ack_o,
  output logic                      dbg_bp_o,
  output logic [core_pkg::xlen-1:0] dbg_rdata_o,
  output logic                      halted_o,
  output logic [1:0]                dsr_o,
  output logic                      step_en_o,
  // core events
  input  logic                      ebreak_i,
  input  logic                      branch_ex_i,
  input  logic                      branch_taken_i,
  input  logic [core_pkg::xlen-1:0] branch_target_i,
  // core writeback
  input  logic                      core_we_i,
  input  core_pkg::reg_addr_t       core_waddr_i,
  input  logic [core_pkg::xlen-1:0] core_wdata_i,
  output logic [core_pkg::xlen-1:0] pc_if_o
);

  import core_pkg::*;

  ////////////////////////////////////////////////////////////
  // control levels between debug unit and pc pipeline
  ////////////////////////////////////////////////////////////

  logic            stall_core;
  logic            stop_req;
  logic            set_npc;
  logic [xlen-1:0] npc;
  logic            trap;
  logic            branch_in_ex;
  logic            branch_taken;
  logic [xlen-1:0] pc_id;
  logic [xlen-1:0] pc_ex;
  logic            sel_spr;

  reg_port_if dbg_port ();

  assign halted_o = stall_core;

  dbg_ctrl i_dbg_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .dbg_stall_i    (dbg_stall_i),
    .dbg_strobe_i   (dbg_strobe_i),
    .dbg_we_i       (dbg_we_i),
    .dbg_addr_i     (dbg_addr_i),
    .dbg_wdata_i    (dbg_wdata_i),
    .dbg_ack_o      (dbg_ack_o),
    .dbg_bp_o       (dbg_bp_o),
    .dbg_rdata_o    (dbg_rdata_o),
    .trap_i         (trap),
    .branch_in_ex_i (branch_in_ex),
    .branch_taken_i (branch_taken),
    .pc_if_i        (pc_if_o),
    .pc_id_i        (pc_id),
    // the branch sits in ex when tracking picks it up
    .branch_pc_i    (pc_ex),
    .stall_core_o   (stall_core),
    .stop_req_o     (stop_req),
    .step_en_o      (step_en_o),
    .set_npc_o      (set_npc),
    .dsr_o          (dsr_o),
    .npc_o          (npc),
    .sel_spr_o      (sel_spr),
    .reg_port       (dbg_port)
  );

  pc_stepper i_pc_stepper (
    .clk             (clk),
    .rst_n           (rst_n),
    .stall_i         (stall_core),
    .stop_req_i      (stop_req),
    .step_en_i       (step_en_o),
    .set_npc_i       (set_npc),
    .npc_i           (npc),
    .ebreak_i        (ebreak_i),
    .branch_ex_i     (branch_ex_i),
    .branch_taken_i  (branch_taken_i),
    .branch_target_i (branch_target_i),
    .trap_o          (trap),
    .branch_in_ex_o  (branch_in_ex),
    .branch_taken_o  (branch_taken),
    .pc_if_o         (pc_if_o),
    .pc_id_o         (pc_id),
    .pc_ex_o         (pc_ex)
  );

  // grant follows the halt level
  reg_file_arb #(
    .num_gpr (num_gpr),
    .num_spr (num_spr)
  ) i_reg_file_arb (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_we_i    (core_we_i),
    .core_waddr_i (core_waddr_i),
    .core_wdata_i (core_wdata_i),
    .dbg_grant_i  (stall_core),
    .sel_spr_i    (sel_spr),
    .dbg_port     (dbg_port)
  );

endmodule

`default_nettype wire

// File: tb/tb_dbg_subsys.sv
// self-checking testbench; a cycle model of the debug rules runs beside the DUT, stops at first error
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_subsys;

  import core_pkg::*;

  // host address map
  localparam logic [15:0] a_npc  = 16'h3000;
  localparam logic [15:0] a_ppc  = 16'h3001;
  localparam logic [15:0] a_dmr1 = 16'h3010;
  localparam logic [15:0] a_dsr  = 16'h3014;
  localparam logic [15:0] a_gpr  = 16'h0400;
  localparam logic [15:0] a_spr  = 16'h0000;

  // model encodings
  localparam int st_idle   = 0;
  localparam int st_dstall = 1;
  localparam int st_halt   = 2;
  localparam int tr_ifid   = 0;
  localparam int tr_ifex   = 1;
  localparam int tr_idex   = 2;

  // cycle budget per test, summed for the watchdog
  localparam int t1_cycles = 20;
  localparam int t2_cycles = 30;
  localparam int t3_cycles = 200;
  localparam int t4_cycles = 80;
  localparam int t5_cycles = 30;
  localparam int t6_cycles = 60;
  localparam int margin_cycles = 200;
  localparam int watchdog_ns = 4 * (5 + t1_cycles + t2_cycles + t3_cycles + t4_cycles
                                    + t5_cycles + t6_cycles + margin_cycles);

  logic        clk;
  logic        rst_n;
  logic        dbg_stall_i;
  logic        dbg_strobe_i;
  logic        dbg_we_i;
  logic [15:0] dbg_addr_i;
  logic [31:0] dbg_wdata_i;
  logic        dbg_ack_o;
  logic        dbg_bp_o;
  logic [31:0] dbg_rdata_o;
  logic        halted_o;
  logic [1:0]  dsr_o;
  logic        step_en_o;
  logic        ebreak_i;
  logic        branch_ex_i;
  logic        branch_taken_i;
  logic [31:0] branch_target_i;
  logic        core_we_i;
  logic [11:0] core_waddr_i;
  logic [31:0] core_wdata_i;
  logic [31:0] pc_if_o;

  // model state
  logic [31:0] m_gpr [32];
  logic [31:0] m_spr [8];
  int          m_state;
  int          m_next;
  int          m_trk;
  int          m_trk_next;
  logic        m_drain;
  logic        m_armed;
  logic        m_done;
  logic [1:0]  m_dmr1;
  logic [1:0]  m_dsr;
  logic [31:0] m_pc_if;
  logic [31:0] m_pc_id;
  logic [31:0] m_pc_ex;
  // model values of the current cycle
  logic        m_trap;
  logic        m_bp;
  logic        m_stall;
  logic        m_stop;
  logic        m_run;
  logic        m_region;
  logic        m_ack;
  logic        m_set_npc;
  logic        m_dbg_wr;
  logic        m_core_wr;
  logic [31:0] m_ppc;
  logic [31:0] m_npc;
  logic [31:0] m_rdata;
  int          check_count;

  dbg_subsys_top i_dbg_subsys_top (.*);

  task automatic end_in_failure(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    end_in_failure($sformatf("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                             $time, name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // clock, reset, watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    end_in_failure("watchdog expired before the tests finished");
  end

  // a breakpoint pulse lasts one cycle and leaves the core halted
  bp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                                 dbg_bp_o |=> (!dbg_bp_o && halted_o))
    else end_in_failure("dbg_bp_o held longer than one cycle or halted_o dropped after it");

  ////////////////////////////////////////////////////////////
  // reference model, evaluated mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      m_trap = ebreak_i || m_drain || m_done;
      m_bp = 1'b0;
      m_stall = 1'b0;
      m_stop = 1'b0;
      m_next = m_state;
      case (m_state)
        st_idle: begin
          if (m_trap) begin
            m_bp = 1'b1;
            m_stall = 1'b1;
            m_next = st_halt;
          end else if (dbg_stall_i) begin
            m_stop = 1'b1;
            m_next = st_dstall;
          end
        end
        st_dstall: begin
          m_stop = 1'b1;
          if (m_trap) begin
            m_stall = 1'b1;
            m_next = st_halt;
          end
        end
        default: begin
          m_stall = 1'b1;
          if (!dbg_stall_i) m_next = st_idle;
        end
      endcase
      m_run = !m_stall && !m_stop;
      m_region = dbg_addr_i[15:11] == 5'b00110;
      m_ack = dbg_strobe_i && (m_region || m_state == st_halt);
      m_set_npc = dbg_strobe_i && dbg_we_i && m_region && dbg_addr_i[10:0] == 11'd0;
      m_dbg_wr = dbg_strobe_i && dbg_we_i && !m_region && m_state == st_halt;
      m_core_wr = core_we_i && !m_stall && core_waddr_i < 12'd32;
      // pc pair by tracking state
      m_ppc = (m_trk == tr_ifid) ? m_pc_id : m_pc_ex;
      m_npc = (m_trk == tr_idex) ? m_pc_id : m_pc_if;
      m_trk_next = m_trk;
      if (m_trk == tr_idex && m_set_npc) m_trk_next = tr_ifex;
      if (m_stall && m_state != st_halt) begin
        if (!branch_ex_i) m_trk_next = tr_ifid;
        else if (branch_taken_i) m_trk_next = tr_ifex;
        else m_trk_next = tr_idex;
      end
      m_rdata = '0;
      if (dbg_strobe_i && m_region) begin
        case (dbg_addr_i[10:0])
          11'd0: m_rdata = m_npc;
          11'd1: m_rdata = m_ppc;
          11'd16: if (!dbg_we_i) m_rdata[23:22] = m_dmr1;
          11'd20: if (!dbg_we_i) m_rdata[7:6] = m_dsr;
          default: m_rdata = '0;
        endcase
      end else if (m_ack && !dbg_we_i) begin
        if (dbg_addr_i[15:10] == 6'b000001) m_rdata = m_gpr[dbg_addr_i[4:0]];
        else if (dbg_addr_i[11:0] < 12'd8) m_rdata = m_spr[dbg_addr_i[2:0]];
      end
      // compare against the DUT
      assert (halted_o === m_stall) else report_mismatch("halted_o", 32'(halted_o), 32'(m_stall));
      assert (dbg_bp_o === m_bp) else report_mismatch("dbg_bp_o", 32'(dbg_bp_o), 32'(m_bp));
      assert (dbg_ack_o === m_ack) else report_mismatch("dbg_ack_o", 32'(dbg_ack_o), 32'(m_ack));
      assert (dbg_rdata_o === m_rdata) else report_mismatch("dbg_rdata_o", dbg_rdata_o, m_rdata);
      assert (pc_if_o === m_pc_if) else report_mismatch("pc_if_o", pc_if_o, m_pc_if);
      assert (step_en_o === m_dmr1[0])
        else report_mismatch("step_en_o", 32'(step_en_o), 32'(m_dmr1[0]));
      assert (dsr_o === m_dsr) else report_mismatch("dsr_o", 32'(dsr_o), 32'(m_dsr));
      check_count++;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_state <= st_idle;
      m_trk <= tr_ifid;
      m_drain <= 1'b0;
      m_armed <= 1'b0;
      m_done <= 1'b0;
      m_dmr1 <= '0;
      m_dsr <= '0;
      m_pc_if <= reset_pc;
      m_pc_id <= reset_pc;
      m_pc_ex <= reset_pc;
      for (int i = 0; i < 32; i++) m_gpr[i] <= '0;
      for (int j = 0; j < 8; j++) m_spr[j] <= '0;
      m_next = st_idle;
      m_trk_next = tr_ifid;
      m_stall = 1'b0;
      m_stop = 1'b0;
      m_run = 1'b0;
      m_set_npc = 1'b0;
      m_dbg_wr = 1'b0;
      m_core_wr = 1'b0;
    end else begin
      m_state <= m_next;
      m_trk <= m_trk_next;
      if (m_set_npc) begin
        m_pc_if <= dbg_wdata_i;
      end else if (m_run) begin
        m_pc_if <= (branch_ex_i && branch_taken_i) ? branch_target_i : m_pc_if + pc_step;
        m_pc_id <= m_pc_if;
        m_pc_ex <= m_pc_id;
      end
      m_drain <= m_stop && !m_drain;
      if (m_stall) begin
        m_armed <= m_dmr1[0];
        m_done <= 1'b0;
      end else if (m_run) begin
        m_done <= m_armed;
        m_armed <= 1'b0;
      end
      if (dbg_strobe_i && dbg_we_i && m_region && dbg_addr_i[10:0] == 11'd16)
        m_dmr1 <= dbg_wdata_i[23:22];
      if (dbg_strobe_i && dbg_we_i && m_region && dbg_addr_i[10:0] == 11'd20)
        m_dsr <= dbg_wdata_i[7:6];
      if (m_dbg_wr) begin
        if (dbg_addr_i[15:10] == 6'b000001) m_gpr[dbg_addr_i[4:0]] <= dbg_wdata_i;
        else if (dbg_addr_i[11:0] < 12'd8) m_spr[dbg_addr_i[2:0]] <= dbg_wdata_i;
      end else if (m_core_wr) begin
        m_gpr[core_waddr_i[4:0]] <= core_wdata_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // one host access for one cycle
  task automatic host_access(input logic we, input logic [15:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    dbg_strobe_i = 1'b1;
    dbg_we_i = we;
    dbg_addr_i = addr;
    dbg_wdata_i = data;
    @(posedge clk);
    #1;
    dbg_strobe_i = 1'b0;
    dbg_we_i = 1'b0;
  endtask

  task automatic wait_halted(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 40) end_in_failure("halted_o did not reach the expected level in time");
    end while (halted_o !== level);
  endtask

  task automatic halt_core();
    @(posedge clk);
    #1;
    dbg_stall_i = 1'b1;
    wait_halted(1'b1);
  endtask

  task automatic release_core();
    @(posedge clk);
    #1;
    dbg_stall_i = 1'b0;
    wait_halted(1'b0);
  endtask

  // branch sits in ex one running cycle before the breakpoint
  // the host also asks to stay halted
  task automatic break_with_branch(input logic in_ex, input logic taken);
    logic [31:0] tgt;
    tgt = $urandom();
    @(posedge clk);
    #1;
    branch_ex_i = in_ex;
    branch_taken_i = taken;
    branch_target_i = {tgt[31:2], 2'b00};
    @(posedge clk);
    #1;
    ebreak_i = 1'b1;
    dbg_stall_i = 1'b1;
    @(posedge clk);
    #1;
    ebreak_i = 1'b0;
    branch_ex_i = 1'b0;
    branch_taken_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] pc_before;
    logic [31:0] npc_val;
    void'($urandom(74842));
    check_count = 0;
    rst_n = 1'b0;
    dbg_stall_i = 1'b0;
    dbg_strobe_i = 1'b0;
    dbg_we_i = 1'b0;
    dbg_addr_i = '0;
    dbg_wdata_i = '0;
    ebreak_i = 1'b0;
    branch_ex_i = 1'b0;
    branch_taken_i = 1'b0;
    branch_target_i = '0;
    core_we_i = 1'b0;
    core_waddr_i = '0;
    core_wdata_i = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset state
    host_access(1'b0, a_dmr1, '0);
    host_access(1'b0, a_dsr, '0);

    // debug region while running, step bit kept off
    r = $urandom();
    host_access(1'b1, a_dmr1, r & ~32'h0040_0000);
    host_access(1'b0, a_dmr1, '0);
    host_access(1'b1, a_dsr, $urandom());
    host_access(1'b0, a_dsr, '0);
    host_access(1'b1, a_gpr + 16'd5, $urandom());
    host_access(1'b0, a_gpr + 16'd5, '0);

    // core writeback while running, then host halt
    repeat (6) begin
      r = $urandom();
      @(posedge clk);
      #1;
      core_we_i = 1'b1;
      core_waddr_i = {7'd0, r[4:0]};
      core_wdata_i = $urandom();
    end
    @(posedge clk);
    #1;
    core_we_i = 1'b0;
    halt_core();
    for (int i = 0; i < 32; i++) host_access(1'b0, a_gpr + 16'(i), '0);
    repeat (8) begin
      r = $urandom();
      host_access(1'b1, a_gpr + 16'(r[4:0]), $urandom());
      host_access(1'b0, a_gpr + 16'(r[4:0]), '0);
      host_access(1'b1, a_spr + 16'(r[7:5]), $urandom());
      host_access(1'b0, a_spr + 16'(r[7:5]), '0);
    end

    // breakpoints with no branch, taken and not-taken branch in EX
    for (int k = 0; k < 3; k++) begin
      release_core();
      repeat (4) @(posedge clk);
      break_with_branch(k != 0, k == 1);
      wait_halted(1'b1);
      host_access(1'b0, a_ppc, '0);
      host_access(1'b0, a_npc, '0);
    end

    // npc write and resume
    r = $urandom();
    npc_val = {r[31:2], 2'b00};
    host_access(1'b1, a_npc, npc_val);
    release_core();
    assert (pc_if_o === npc_val) else report_mismatch("pc_if_o", pc_if_o, npc_val);
    @(negedge clk);
    assert (pc_if_o === npc_val + pc_step)
      else report_mismatch("pc_if_o", pc_if_o, npc_val + pc_step);
    halt_core();

    // single step
    host_access(1'b1, a_dmr1, 32'h0040_0000);
    repeat (3) begin
      pc_before = m_pc_if;
      release_core();
      wait_halted(1'b1);
      @(posedge clk);
      #1;
      dbg_stall_i = 1'b1;
      @(negedge clk);
      assert (pc_if_o === pc_before + pc_step)
        else report_mismatch("pc_if_o", pc_if_o, pc_before + pc_step);
    end

    repeat (4) @(posedge clk);
    if (check_count > 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      end_in_failure("no model checks ran");
    end
  end

endmodule

`default_nettype wire

// File: src.f
logic/core_pkg.sv
logic/dbg_pkg.sv
logic/reg_port_if.sv
logic/dbg_ctrl.sv
logic/pc_stepper.sv
logic/reg_file_arb.sv
logic/dbg_subsys_top.sv
tb/tb_dbg_subsys.sv

// File: Makefile
# Verilator build and run of the debug subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_dbg_subsys
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
